//--- test/video_tests.mem
// kind_name_mode_pal_tvpix_vgapix_word, all hex; kind 1 writes word into the CRAM at address vgapix
// kind 2 is a pixel test and word is the colour it should show; mode bits from 7 down are
// vga_on tv_blank vga_blank vga_line tv_hires vga_hires plex_sel[1] plex_sel[0]
1_00_00_0_00_10_2267
1_00_00_0_00_11_7C34
1_00_00_0_00_12_09BE
1_00_00_0_00_53_4A52
1_00_00_0_00_5A_3300
1_00_00_0_00_79_1234
1_00_00_0_00_7C_6E5B
1_00_00_0_00_20_5555
2_01_80_0_00_10_2267
2_02_90_0_00_10_2267
2_03_80_0_00_11_7C34
2_04_90_0_00_11_7C34
2_05_80_0_00_12_09BE
2_06_90_0_00_12_09BE
2_07_85_5_00_A3_4A52
2_08_86_5_00_A3_3300
1_00_00_0_00_53_0421
2_09_85_5_00_A3_0421
2_0A_00_0_20_00_5555
2_0B_0A_7_C9_00_1234
2_0C_09_7_C9_00_6E5B
2_0D_A0_0_00_11_7C34
2_0E_C0_0_00_11_7C34
2_0F_40_0_20_00_5555
2_10_20_0_20_00_5555
2_11_80_0_00_11_7C34
2_12_00_0_10_00_2267

//--- video_out.f
+incdir+src
src/video_pkg.sv
src/pixel_if.sv
src/color_if.sv
src/pixel_select.sv
src/palette_cram.sv
src/dac_dither.sv
src/video_out.sv
test/video_out_assert.sv
test/video_out_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the video_out testbench with Verilator from the project root
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module video_out_tb -Mdir obj_dir -o video_out_sim -f video_out.f

./obj_dir/video_out_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- test/video_out_tb.sv
// run from the project root; the CRAM has no reset, so every looked-up index is written first
`timescale 1ns/100ps
`include "video_params.svh"

module video_out_tb;

	// PWM patterns for fine levels 0..7, one byte each, level 0 lowest
	localparam logic [63:0] pwm_table = {8'hDF, 8'hD7, 8'hA7, 8'hA5, 8'h45, 8'h41, 8'h01, 8'h00};

	logic        clk;
	logic        rst;
	logic        c3;
	logic        vga_on;
	logic        tv_blank;
	logic        vga_blank;
	logic        vga_line;
	logic [1:0]  plex_sel;
	logic        tv_hires;
	logic        vga_hires;
	logic [3:0]  palsel;
	logic [14:0] cram_data;
	logic [7:0]  cram_addr;
	logic        cram_we;
	logic [7:0]  tv_pix;
	logic [7:0]  vga_pix;
	logic [1:0]  vred0;
	logic [1:0]  vgrn0;
	logic [1:0]  vblu0;
	logic [1:0]  vred1;
	logic [1:0]  vgrn1;
	logic [1:0]  vblu1;
	logic [55:0] tests [0:63];
	logic [2:0]  ph_model;
	int          num_tests;
	int          cycle_limit = 0;
	int          errors = 0;
	int          checks = 0;

	video_out dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reference phase counter, counts from reset
	always @(posedge clk)
	begin
		if (rst)
			ph_model <= 3'd0;
		else
			ph_model <= ph_model + 3'd1;
	end

	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles <= cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("simulation hung: no end of tests after %0d cycles", cycles);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [1:0] dithered_level(input logic [4:0] ch, input logic [1:0] phase,
		input logic k);
		logic [5:0] pos;
		logic [1:0] coarse;
		pos = {ch[2:0], phase, k};
		coarse = ch[4:3];
		if (pwm_table[pos] && coarse != 2'd3)
			return coarse + 2'd1;
		return coarse;
	endfunction

	function automatic logic [5:0] expected_levels(input logic [14:0] word,
		input logic [1:0] phase, input logic k);
		return {dithered_level(word[14:10], phase, k), dithered_level(word[9:5], phase, k),
			dithered_level(word[4:0], phase, k)};
	endfunction

	task automatic compare_levels(input string name, input logic [5:0] exp0,
		input logic [5:0] exp1);
		logic [5:0] act0;
		logic [5:0] act1;
		act0 = {vred0, vgrn0, vblu0};
		act1 = {vred1, vgrn1, vblu1};
		checks++;
		if (act0 !== exp0)
		begin
			errors++;
			$display("FAIL test %s dac0: expected %h actual %h", name, exp0, act0);
		end
		if (act1 !== exp1)
		begin
			errors++;
			$display("FAIL test %s dac1: expected %h actual %h", name, exp1, act1);
		end
	endtask

	task automatic write_palette(input logic [7:0] addr, input logic [14:0] word);
		@(posedge clk);
		cram_we   <= 1'b1;
		cram_addr <= addr;
		cram_data <= word;
		@(posedge clk);
		cram_we <= 1'b0;
	endtask

	task automatic check_pixel(input logic [55:0] rec);
		logic [7:0] mode;
		logic [5:0] exp0;
		logic [5:0] exp1;
		logic [1:0] phase;
		logic [2:0] ph_used;
		logic       pick;
		logic       captured;
		mode = rec[43:36];
		@(posedge clk);
		vga_on    <= mode[7];
		tv_blank  <= mode[6];
		vga_blank <= mode[5];
		vga_line  <= mode[4];
		tv_hires  <= mode[3];
		vga_hires <= mode[2];
		plex_sel  <= mode[1:0];
		palsel    <= rec[35:32];
		vga_pix   <= rec[23:16];
		c3        <= 1'b0;
		// TV: junk while c3 is low, test pixel once c3 goes high
		captured = mode[7];
		while (!captured)
		begin
			pick = ($urandom_range(1, 0) != 0);
			c3 <= pick;
			tv_pix <= pick ? rec[31:24] : 8'($urandom);
			captured = pick;
			@(posedge clk);
		end
		c3 <= 1'b0;
		if (!mode[7])
		begin
			// c3 stays low for one more cycle while the TV input moves on
			tv_pix <= ~rec[31:24];
			@(posedge clk);
			tv_pix <= 8'($urandom);
		end
		// first pipeline stage samples here; blank after it so a wrong latency shows
		@(posedge clk);
		if (mode[7])
			vga_blank <= 1'b1;
		else
			tv_blank <= 1'b1;
		repeat (`VIDEO_LATENCY - 1) @(posedge clk);
		@(negedge clk);
		ph_used = ph_model - 3'd1;
		phase = {mode[7] ? mode[4] : ph_used[1], ph_used[0]};
		exp0 = 6'd0;
		exp1 = 6'd0;
		if (!(mode[7] ? mode[5] : mode[6]))
		begin
			exp0 = expected_levels(rec[14:0], phase, 1'b0);
			exp1 = expected_levels(rec[14:0], phase, 1'b1);
		end
		compare_levels($sformatf("%02h", rec[51:44]), exp0, exp1);
	endtask

	initial
	begin
		void'($urandom(60945));
		rst       = 1'b1;
		c3        = 1'b0;
		vga_on    = 1'b1;
		tv_blank  = 1'b1;
		vga_blank = 1'b1;
		vga_line  = 1'b0;
		plex_sel  = 2'd0;
		tv_hires  = 1'b0;
		vga_hires = 1'b0;
		palsel    = 4'd0;
		cram_data = 15'd0;
		cram_addr = 8'd0;
		cram_we   = 1'b0;
		tv_pix    = 8'd0;
		vga_pix   = 8'd0;
		for (int i = 0; i < 64; i++)
			tests[i] = '0;
		$readmemh("test/video_tests.mem", tests);
		num_tests = 0;
		while (num_tests < 64 && tests[num_tests][55:52] != 4'h0)
			num_tests++;
		cycle_limit = num_tests * 8 + 100;
		if (num_tests == 0)
		begin
			errors++;
			$display("no test records could be read from test/video_tests.mem");
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// inputs still blanked, levels stay at zero
		repeat (4)
		begin
			@(negedge clk);
			compare_levels("reset", 6'd0, 6'd0);
		end
		for (int i = 0; i < num_tests; i++)
		begin
			if (tests[i][55:52] == 4'h1)
				write_palette(tests[i][23:16], tests[i][14:0]);
			else
				check_pixel(tests[i]);
		end
		if (dut_i.dac_dither_i.video_out_assert_i.fail_count != 0)
		begin
			errors++;
			$display("bound assertions failed during the run");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- test/video_out_assert.sv
// covers the DAC stage only; CRAM contents and index forming are left to the testbench
`timescale 1ns/100ps

module video_out_assert
(
	input logic        clk,
	input logic        rst,
	input logic        blank,
	input logic [14:0] color,
	input logic [5:0]  dac0,
	input logic [5:0]  dac1
);

	int         fail_count = 0;
	logic [2:0] full_in;
	logic [2:0] full_out;

	// per channel full-scale flags, red first
	assign full_in = {color[14:13] == 2'b11, color[9:8] == 2'b11, color[4:3] == 2'b11};
	assign full_out = {dac0[5:4] == 2'b11 && dac1[5:4] == 2'b11,
		dac0[3:2] == 2'b11 && dac1[3:2] == 2'b11,
		dac0[1:0] == 2'b11 && dac1[1:0] == 2'b11};

	// reset clears both levels and blanks the colour stage
	assert property (@(posedge clk) rst |=> (dac0 == 6'd0 && dac1 == 6'd0 && blank))
	else
	begin
		fail_count++;
		$error("DAC levels or colour blank not cleared after reset");
	end

	assert property (@(posedge clk) blank |=> (dac0 == 6'd0 && dac1 == 6'd0))
	else
	begin
		fail_count++;
		$error("DAC levels not zero after a blanked colour");
	end

	// coarse 3 must not wrap when the pattern bit is set
	assert property (@(posedge clk) disable iff (rst)
		(!blank && full_in != 3'b000) |=> ((full_out & $past(full_in)) == $past(full_in)))
	else
	begin
		fail_count++;
		$error("full-scale channel left full scale");
	end

endmodule

bind dac_dither video_out_assert video_out_assert_i (
	.clk   (clk),
	.rst   (rst),
	.blank (col.blank),
	.color (col.color),
	.dac0  (dac0),
	.dac1  (dac1)
);

//--- src/video_out.sv
// synchronous only; vXXX0 and vXXX1 are the two half-cycle levels, muxed outside by a DDR cell
`timescale 1ns/100ps
`include "video_params.svh"

module video_out
	import video_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    c3,
	input  logic                    vga_on,
	input  logic                    tv_blank,
	input  logic                    vga_blank,
	input  logic                    vga_line,
	input  logic [1:0]              plex_sel,
	input  logic                    tv_hires,
	input  logic                    vga_hires,
	input  logic [3:0]              palsel,
	input  logic [14:0]             cram_data,
	input  logic [`VIDEO_IDX_W-1:0] cram_addr,
	input  logic                    cram_we,
	input  logic [`VIDEO_IDX_W-1:0] tv_pix,
	input  logic [`VIDEO_IDX_W-1:0] vga_pix,
	output logic [1:0]              vred0,
	output logic [1:0]              vgrn0,
	output logic [1:0]              vblu0,
	output logic [1:0]              vred1,
	output logic [1:0]              vgrn1,
	output logic [1:0]              vblu1
);

	pixel_if pix_bus ();
	color_if col_bus ();

	dac_rgb_t dac0;
	dac_rgb_t dac1;

	pixel_select pixel_select_i (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.vga_line  (vga_line),
		.plex_sel  (plex_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.palsel    (palsel),
		.c3        (c3),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.pix       (pix_bus.src_mp)
	);

	palette_cram palette_cram_i (
		.clk       (clk),
		.rst       (rst),
		.cram_we   (cram_we),
		.cram_addr (cram_addr),
		.cram_data (rgb15_t'(cram_data)),
		.pix       (pix_bus.dst_mp),
		.col       (col_bus.src_mp)
	);

	dac_dither dac_dither_i (
		.clk  (clk),
		.rst  (rst),
		.col  (col_bus.dst_mp),
		.dac0 (dac0),
		.dac1 (dac1)
	);

	// split the DAC structs onto the pins
	assign vred0 = dac0.red;
	assign vgrn0 = dac0.grn;
	assign vblu0 = dac0.blu;
	assign vred1 = dac1.red;
	assign vgrn1 = dac1.grn;
	assign vblu1 = dac1.blu;

endmodule

//--- src/dac_dither.sv
// two sub-phase values per clock; the board's DDR output cell must pick dac0 then dac1
`timescale 1ns/100ps
`include "video_params.svh"

module dac_dither
	import video_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	color_if.dst_mp col,
	output dac_rgb_t dac0,
	output dac_rgb_t dac1
);

	logic [2:0] ph;
	logic [1:0] phase;

	// ordered PWM patterns, one per fine level
	function automatic logic [7:0] pwm_pattern(input logic [`VIDEO_FINE_W-1:0] fine);
		case (fine)
			3'd0:    return 8'b00000000;
			3'd1:    return 8'b00000001;
			3'd2:    return 8'b01000001;
			3'd3:    return 8'b01000101;
			3'd4:    return 8'b10100101;
			3'd5:    return 8'b10100111;
			3'd6:    return 8'b11010111;
			default: return 8'b11011111;
		endcase
	endfunction

	// bump coarse by one where the pattern bit is set, never past full scale
	function automatic logic [`VIDEO_COARSE_W-1:0] dither_level(input chan_t ch,
		input logic [2:0] bit_sel);
		logic [7:0] pat;
		pat = pwm_pattern(ch.fine);
		if (pat[bit_sel] && (ch.coarse != '1))
			return ch.coarse + 1'b1;
		else
			return ch.coarse;
	endfunction

	// free-running phase counter
	always_ff @(posedge clk)
	begin
		if (rst)
			ph <= 3'd0;
		else
			ph <= ph + 3'd1;
	end

	// VGA takes the line parity so adjacent lines use opposite pattern halves
	assign phase = {(col.src == SRC_VGA) ? col.line : ph[1], ph[0]};

	always_ff @(posedge clk)
	begin
		if (rst || col.blank)
		begin
			dac0 <= '0;
			dac1 <= '0;
		end
		else
		begin
			dac0.red <= dither_level(col.color.red, {phase, 1'b0});
			dac0.grn <= dither_level(col.color.grn, {phase, 1'b0});
			dac0.blu <= dither_level(col.color.blu, {phase, 1'b0});
			dac1.red <= dither_level(col.color.red, {phase, 1'b1});
			dac1.grn <= dither_level(col.color.grn, {phase, 1'b1});
			dac1.blu <= dither_level(col.color.blu, {phase, 1'b1});
		end
	end

endmodule

//--- src/palette_cram.sv
// contents are undefined until the CPU writes them; read during a same-address write gives old word
`timescale 1ns/100ps
`include "video_params.svh"

module palette_cram
	import video_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cram_we,
	input  logic [`VIDEO_IDX_W-1:0] cram_addr,
	input  rgb15_t                  cram_data,
	pixel_if.dst_mp                 pix,
	color_if.src_mp                 col
);

	rgb15_t mem [0:`VIDEO_CRAM_DEPTH-1];

	// CPU write port and video read port share the clock
	always_ff @(posedge clk)
	begin
		if (cram_we)
			mem[cram_addr] <= cram_data;
		col.color <= mem[pix.index];
	end

	// sideband follows the read latency
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			col.blank <= 1'b1;
			col.src   <= SRC_TV;
			col.line  <= 1'b0;
		end
		else
		begin
			col.blank <= pix.blank;
			col.src   <= pix.src;
			col.line  <= pix.line;
		end
	end

endmodule

//--- src/pixel_select.sv
// tv_pix must be stable while c3 is high; TV blank and hires are taken directly, not via c3
`timescale 1ns/100ps
`include "video_params.svh"

module pixel_select
	import video_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    vga_on,
	input  logic                    tv_blank,
	input  logic                    vga_blank,
	input  logic                    vga_line,
	input  logic [1:0]              plex_sel,
	input  logic                    tv_hires,
	input  logic                    vga_hires,
	input  logic [3:0]              palsel,
	input  logic                    c3,
	input  logic [`VIDEO_IDX_W-1:0] tv_pix,
	input  logic [`VIDEO_IDX_W-1:0] vga_pix,
	pixel_if.src_mp                 pix
);

	logic [`VIDEO_IDX_W-1:0] tv_pix_q;
	logic [`VIDEO_IDX_W-1:0] cur_pix;
	logic [`VIDEO_IDX_W-1:0] cur_index;
	logic                    cur_hires;
	logic                    cur_blank;
	logic                    cur_nib;
	video_src_t              cur_src;

	// TV pixel sampled on the pixel clock enable
	always_ff @(posedge clk)
	begin
		if (c3)
			tv_pix_q <= tv_pix;
	end

	// source mux
	always_comb
	begin
		cur_src   = vga_on ? SRC_VGA : SRC_TV;
		cur_pix   = vga_on ? vga_pix : tv_pix_q;
		cur_hires = vga_on ? vga_hires : tv_hires;
		cur_blank = vga_on ? vga_blank : tv_blank;
		cur_nib   = vga_on ? plex_sel[0] : plex_sel[1];
	end

	// hires uses one nibble, palsel supplies the upper half
	always_comb
	begin
		if (!cur_hires)
			cur_index = cur_pix;
		else if (cur_nib)
			cur_index = {palsel, cur_pix[3:0]};
		else
			cur_index = {palsel, cur_pix[7:4]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pix.blank <= 1'b1;
			pix.src   <= SRC_TV;
			pix.line  <= 1'b0;
		end
		else
		begin
			pix.blank <= cur_blank;
			pix.src   <= cur_src;
			pix.line  <= vga_line;
		end
	end

	always_ff @(posedge clk)
	begin
		pix.index <= cur_index;
	end

endmodule

//--- src/color_if.sv
// free-running stream, no handshake; one looked-up colour per clock
`timescale 1ns/100ps

interface color_if
	import video_pkg::*;
();

	// colour word read from the CRAM
	rgb15_t color;

	// sideband aligned with color
	logic       blank;
	video_src_t src;
	logic       line;

	modport src_mp
	(
		output color,
		output blank,
		output src,
		output line
	);

	modport dst_mp
	(
		input color,
		input blank,
		input src,
		input line
	);

endinterface

//--- src/pixel_if.sv
// free-running stream, no handshake; one palette index per clock
`timescale 1ns/100ps
`include "video_params.svh"

interface pixel_if
	import video_pkg::*;
();

	// palette index into the colour RAM
	logic [`VIDEO_IDX_W-1:0] index;

	// sideband travelling with the index
	logic       blank;
	video_src_t src;
	logic       line;

	modport src_mp
	(
		output index,
		output blank,
		output src,
		output line
	);

	modport dst_mp
	(
		input index,
		input blank,
		input src,
		input line
	);

endinterface

//--- src/video_pkg.sv
// type definitions only; field order of rgb15_t must match the CPU's CRAM word layout
`include "video_params.svh"

package video_pkg;

	// which pixel source is active
	typedef enum logic
	{
		SRC_TV  = 1'b0,
		SRC_VGA = 1'b1
	} video_src_t;

	// one colour channel, coarse in the upper bits
	typedef struct packed
	{
		logic [`VIDEO_COARSE_W-1:0] coarse;
		logic [`VIDEO_FINE_W-1:0]   fine;
	} chan_t;

	// red sits at bits 14:10, blue at 4:0
	typedef struct packed
	{
		chan_t red;
		chan_t grn;
		chan_t blu;
	} rgb15_t;

	// levels presented to the resistor DAC
	typedef struct packed
	{
		logic [`VIDEO_COARSE_W-1:0] red;
		logic [`VIDEO_COARSE_W-1:0] grn;
		logic [`VIDEO_COARSE_W-1:0] blu;
	} dac_rgb_t;

endpackage

//--- src/video_params.svh
// widths are sized for a 15-bit CRAM word and a 2-bit DAC; changing them breaks the dither table
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// palette index width
`define VIDEO_IDX_W 8

// colour RAM entries, one per index value
`define VIDEO_CRAM_DEPTH 256

// per channel fine level, drives the PWM pattern
`define VIDEO_FINE_W 3

// per channel coarse level, same as DAC bits
`define VIDEO_COARSE_W 2

// select, cram read and dac register stages
`define VIDEO_LATENCY 3

`endif
